// ==== pcie_rc_pkg.sv ====
// Stream widths, completion TLP field positions, channel encoding and route states

package pcie_rc_pkg;

  // Stream widths of the 256-bit PCIe user interface
  localparam int tlp_data_w = 256;
  localparam int tlp_keep_w = tlp_data_w / 32;
  localparam int rc_user_w  = 75;

  typedef logic [tlp_data_w-1:0] tlp_data_t;
  typedef logic [tlp_keep_w-1:0] tlp_keep_t;
  typedef logic [rc_user_w-1:0]  rc_user_t;

  // Descriptor channels
  // 0 ch0 host-to-card, 1 ch0 card-to-host, 2 ch1 host-to-card, 3 ch1 card-to-host
  localparam int num_bd_chan = 4;

  typedef logic [$clog2(num_bd_chan)-1:0] bd_chan_t;

  // First beat of a completion carries the BD marker and channel tag
  localparam int bd_flag_bit = 68;
  localparam int bd_chan_lsb = 66;

  // Packet tracker states
  typedef enum logic [1:0] {
    IDLE,
    BD_BODY,
    BYPASS_BODY
  } rc_route_e;

endpackage

// ==== dma_reg_pkg.sv ====
// DMA software-pointer register map and pointer field layout

package dma_reg_pkg;

  localparam int sw_ptr_w     = 27;
  localparam int reg_offset_w = 16;

  typedef logic [sw_ptr_w-1:0]     sw_ptr_t;
  typedef logic [reg_offset_w-1:0] reg_offset_t;

  // Pointer value sits in bits 159:133 of a register write beat
  localparam int sw_ptr_lsb = 133;

  // Software-pointer register offsets, compared against bits 15:0 of the beat
  localparam reg_offset_t ch0_s2c_ptr_offset = 16'h000c;
  localparam reg_offset_t ch0_c2s_ptr_offset = 16'h200c;
  localparam reg_offset_t ch1_s2c_ptr_offset = 16'h010c;
  localparam reg_offset_t ch1_c2s_ptr_offset = 16'h210c;

endpackage

// ==== rc_pkt_tracker.sv ====
// Completion packet tracker FSM holding the BD or bypass route across a packet
`timescale 1ns/1ps

module rc_pkt_tracker (
  input  logic                   user_clk,
  input  logic                   user_reset,
  input  logic                   rc_beat_accept,
  input  logic                   rc_tlast,
  input  pcie_rc_pkg::tlp_data_t rc_tdata,
  output logic                   route_bd,
  output pcie_rc_pkg::bd_chan_t  route_chan
);

  pcie_rc_pkg::rc_route_e state;
  pcie_rc_pkg::rc_route_e state_next;
  pcie_rc_pkg::bd_chan_t  chan_q;
  logic                   first_bd;
  pcie_rc_pkg::bd_chan_t  first_chan;

  // Only meaningful on the first beat of a packet
  assign first_bd   = rc_tdata[pcie_rc_pkg::bd_flag_bit];
  assign first_chan = rc_tdata[pcie_rc_pkg::bd_chan_lsb +: $bits(pcie_rc_pkg::bd_chan_t)];

  always_comb
  begin
    state_next = state;
    case (state)
      pcie_rc_pkg::IDLE:
      begin
        // Single-beat packets never leave IDLE
        if (rc_beat_accept && !rc_tlast)
        begin
          state_next = first_bd ? pcie_rc_pkg::BD_BODY : pcie_rc_pkg::BYPASS_BODY;
        end
      end
      default:
      begin
        if (rc_beat_accept && rc_tlast)
        begin
          state_next = pcie_rc_pkg::IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge user_clk)
  begin
    if (user_reset)
    begin
      state  <= pcie_rc_pkg::IDLE;
      chan_q <= '0;
    end
    else
    begin
      state <= state_next;
      if (state == pcie_rc_pkg::IDLE && rc_beat_accept)
      begin
        chan_q <= first_chan;
      end
    end
  end

  // First beat decodes live, later beats replay the stored decision
  always_comb
  begin
    case (state)
      pcie_rc_pkg::BD_BODY:
      begin
        route_bd   = 1'b1;
        route_chan = chan_q;
      end
      pcie_rc_pkg::BYPASS_BODY:
      begin
        route_bd   = 1'b0;
        route_chan = chan_q;
      end
      default:
      begin
        route_bd   = first_bd;
        route_chan = first_chan;
      end
    endcase
  end

endmodule

// ==== rc_steer.sv ====
// Completion steering data path to the bypass or one BD channel, with ready select
`timescale 1ns/1ps

module rc_steer (
  input  logic                                rc_tvalid,
  output logic                                rc_tready,
  input  logic                                rc_tlast,
  input  pcie_rc_pkg::tlp_keep_t              rc_tkeep,
  input  pcie_rc_pkg::tlp_data_t              rc_tdata,
  input  pcie_rc_pkg::rc_user_t               rc_tuser,
  input  logic                                route_bd,
  input  pcie_rc_pkg::bd_chan_t               route_chan,
  output logic                                rc_beat_accept,
  output logic                                bp_tvalid,
  input  logic                                bp_tready,
  output logic                                bp_tlast,
  output pcie_rc_pkg::tlp_keep_t              bp_tkeep,
  output pcie_rc_pkg::tlp_data_t              bp_tdata,
  output pcie_rc_pkg::rc_user_t               bp_tuser,
  output logic [pcie_rc_pkg::num_bd_chan-1:0] bd_tvalid,
  input  logic [pcie_rc_pkg::num_bd_chan-1:0] bd_tready,
  output logic                                bd_tlast,
  output pcie_rc_pkg::tlp_data_t              bd_tdata
);

  logic [pcie_rc_pkg::num_bd_chan-1:0] chan_onehot;
  logic [pcie_rc_pkg::num_bd_chan-1:0] bd_sel;

  assign chan_onehot = (pcie_rc_pkg::num_bd_chan)'(1) << route_chan;
  assign bd_sel      = {pcie_rc_pkg::num_bd_chan{route_bd}} & chan_onehot;

  // Valids are qualified by the route so that only one sink sees the beat
  assign bp_tvalid = rc_tvalid & ~route_bd;
  assign bd_tvalid = bd_sel & {pcie_rc_pkg::num_bd_chan{rc_tvalid}};

  // Ready comes only from the selected sink, so a stalled sink holds the input
  assign rc_tready = route_bd ? |(bd_sel & bd_tready) : bp_tready;

  assign rc_beat_accept = rc_tvalid & rc_tready;

  // Payload fans out unmasked; the valids tell the sinks which beat is theirs
  assign bp_tlast = rc_tlast;
  assign bp_tkeep = rc_tkeep;
  assign bp_tdata = rc_tdata;
  assign bp_tuser = rc_tuser;

  assign bd_tlast = rc_tlast;
  assign bd_tdata = rc_tdata;

endmodule

// ==== sw_ptr_snoop.sv ====
// Software-pointer registers of the four DMA channels, loaded from snooped CQ writes
`timescale 1ns/1ps

module sw_ptr_snoop (
  input  logic                   user_clk,
  input  logic                   user_reset,
  input  logic                   cq_tvalid,
  input  logic                   cq_tready,
  input  pcie_rc_pkg::tlp_data_t cq_tdata,
  output dma_reg_pkg::sw_ptr_t   ch0_s2c_sw_ptr,
  output dma_reg_pkg::sw_ptr_t   ch0_c2s_sw_ptr,
  output dma_reg_pkg::sw_ptr_t   ch1_s2c_sw_ptr,
  output dma_reg_pkg::sw_ptr_t   ch1_c2s_sw_ptr
);

  dma_reg_pkg::reg_offset_t cq_offset;
  dma_reg_pkg::sw_ptr_t     cq_ptr;

  assign cq_offset = cq_tdata[$bits(dma_reg_pkg::reg_offset_t)-1:0];
  assign cq_ptr    = cq_tdata[dma_reg_pkg::sw_ptr_lsb +: $bits(dma_reg_pkg::sw_ptr_t)];

  always_ff @(posedge user_clk)
  begin
    if (user_reset)
    begin
      ch0_s2c_sw_ptr <= '0;
      ch0_c2s_sw_ptr <= '0;
      ch1_s2c_sw_ptr <= '0;
      ch1_c2s_sw_ptr <= '0;
    end
    else if (cq_tvalid && cq_tready)
    begin
      // Unlisted offsets leave every pointer untouched
      case (cq_offset)
        dma_reg_pkg::ch0_s2c_ptr_offset: ch0_s2c_sw_ptr <= cq_ptr;
        dma_reg_pkg::ch0_c2s_ptr_offset: ch0_c2s_sw_ptr <= cq_ptr;
        dma_reg_pkg::ch1_s2c_ptr_offset: ch1_s2c_sw_ptr <= cq_ptr;
        dma_reg_pkg::ch1_c2s_ptr_offset: ch1_c2s_sw_ptr <= cq_ptr;
        default:
        begin
        end
      endcase
    end
  end

endmodule

// ==== rc_cq_top.sv ====
// Receive side top: completion tracker and steering plus CQ software-pointer snoop
`timescale 1ns/1ps

module rc_cq_top (
  input  logic                                user_clk,
  input  logic                                user_reset,

  // Requester completions from the PCIe endpoint
  input  logic                                rc_tvalid,
  output logic                                rc_tready,
  input  logic                                rc_tlast,
  input  pcie_rc_pkg::tlp_keep_t              rc_tkeep,
  input  pcie_rc_pkg::tlp_data_t              rc_tdata,
  input  pcie_rc_pkg::rc_user_t               rc_tuser,

  // Non-BD completions toward the response queue
  output logic                                bp_tvalid,
  input  logic                                bp_tready,
  output logic                                bp_tlast,
  output pcie_rc_pkg::tlp_keep_t              bp_tkeep,
  output pcie_rc_pkg::tlp_data_t              bp_tdata,
  output pcie_rc_pkg::rc_user_t               bp_tuser,

  // BD completions, one valid and ready per channel
  output logic [pcie_rc_pkg::num_bd_chan-1:0] bd_tvalid,
  input  logic [pcie_rc_pkg::num_bd_chan-1:0] bd_tready,
  output logic                                bd_tlast,
  output pcie_rc_pkg::tlp_data_t              bd_tdata,

  // Completer requests, observed only
  input  logic                                cq_tvalid,
  input  logic                                cq_tready,
  input  pcie_rc_pkg::tlp_data_t              cq_tdata,

  output dma_reg_pkg::sw_ptr_t                ch0_s2c_sw_ptr,
  output dma_reg_pkg::sw_ptr_t                ch0_c2s_sw_ptr,
  output dma_reg_pkg::sw_ptr_t                ch1_s2c_sw_ptr,
  output dma_reg_pkg::sw_ptr_t                ch1_c2s_sw_ptr
);

  logic                  route_bd;
  pcie_rc_pkg::bd_chan_t route_chan;
  logic                  rc_beat_accept;

  rc_pkt_tracker tracker_i (
    .user_clk       (user_clk),
    .user_reset     (user_reset),
    .rc_beat_accept (rc_beat_accept),
    .rc_tlast       (rc_tlast),
    .rc_tdata       (rc_tdata),
    .route_bd       (route_bd),
    .route_chan     (route_chan)
  );

  rc_steer steer_i (
    .rc_tvalid      (rc_tvalid),
    .rc_tready      (rc_tready),
    .rc_tlast       (rc_tlast),
    .rc_tkeep       (rc_tkeep),
    .rc_tdata       (rc_tdata),
    .rc_tuser       (rc_tuser),
    .route_bd       (route_bd),
    .route_chan     (route_chan),
    .rc_beat_accept (rc_beat_accept),
    .bp_tvalid      (bp_tvalid),
    .bp_tready      (bp_tready),
    .bp_tlast       (bp_tlast),
    .bp_tkeep       (bp_tkeep),
    .bp_tdata       (bp_tdata),
    .bp_tuser       (bp_tuser),
    .bd_tvalid      (bd_tvalid),
    .bd_tready      (bd_tready),
    .bd_tlast       (bd_tlast),
    .bd_tdata       (bd_tdata)
  );

  sw_ptr_snoop snoop_i (
    .user_clk       (user_clk),
    .user_reset     (user_reset),
    .cq_tvalid      (cq_tvalid),
    .cq_tready      (cq_tready),
    .cq_tdata       (cq_tdata),
    .ch0_s2c_sw_ptr (ch0_s2c_sw_ptr),
    .ch0_c2s_sw_ptr (ch0_c2s_sw_ptr),
    .ch1_s2c_sw_ptr (ch1_s2c_sw_ptr),
    .ch1_c2s_sw_ptr (ch1_c2s_sw_ptr)
  );

endmodule

// ==== rc_cq_sva.sv ====
// Bound assertions on completion sink exclusivity, valid gating and route stability
`timescale 1ns/1ps

module rc_cq_sva (
  input logic                                user_clk,
  input logic                                user_reset,
  input logic                                rc_tvalid,
  input logic                                bp_tvalid,
  input logic [pcie_rc_pkg::num_bd_chan-1:0] bd_tvalid,
  input logic                                route_bd,
  input pcie_rc_pkg::bd_chan_t               route_chan,
  input pcie_rc_pkg::rc_route_e              state
);

  // A beat reaches one sink at most
  a_one_sink: assert property (@(posedge user_clk) disable iff (user_reset)
    $onehot0({bp_tvalid, bd_tvalid}))
    else $error("More than one completion sink sees a valid beat");

  a_valid_gated: assert property (@(posedge user_clk) disable iff (user_reset)
    (bp_tvalid || (|bd_tvalid)) |-> rc_tvalid)
    else $error("Output valid raised without an input beat");

  // Inside a packet the route replays the first-beat decision
  a_route_held: assert property (@(posedge user_clk) disable iff (user_reset)
    (state != pcie_rc_pkg::IDLE) |-> ($stable(route_bd) && $stable(route_chan)))
    else $error("Route changed in the middle of a packet");

endmodule

bind rc_cq_top rc_cq_sva sva_i (
  .user_clk   (user_clk),
  .user_reset (user_reset),
  .rc_tvalid  (rc_tvalid),
  .bp_tvalid  (bp_tvalid),
  .bd_tvalid  (bd_tvalid),
  .route_bd   (route_bd),
  .route_chan (route_chan),
  .state      (tracker_i.state)
);

// ==== tb_rc_cq_top.sv ====
// Directed testbench for rc_cq_top with LCG payloads, value checks, timeout and verdict
`timescale 1ns/1ps

module tb_rc_cq_top;

  // The tests take about 50 cycles and the limit leaves a wide margin
  localparam int max_cycles = 2000;
  localparam dma_reg_pkg::reg_offset_t ptr_offsets [4] = '{
    dma_reg_pkg::ch0_s2c_ptr_offset, dma_reg_pkg::ch0_c2s_ptr_offset,
    dma_reg_pkg::ch1_s2c_ptr_offset, dma_reg_pkg::ch1_c2s_ptr_offset
  };

  logic                                user_clk = 1'b0;
  logic                                user_reset;
  logic                                rc_tvalid;
  logic                                rc_tready;
  logic                                rc_tlast;
  pcie_rc_pkg::tlp_keep_t              rc_tkeep;
  pcie_rc_pkg::tlp_data_t              rc_tdata;
  pcie_rc_pkg::rc_user_t               rc_tuser;
  logic                                bp_tvalid;
  logic                                bp_tready;
  logic                                bp_tlast;
  pcie_rc_pkg::tlp_keep_t              bp_tkeep;
  pcie_rc_pkg::tlp_data_t              bp_tdata;
  pcie_rc_pkg::rc_user_t               bp_tuser;
  logic [pcie_rc_pkg::num_bd_chan-1:0] bd_tvalid;
  logic [pcie_rc_pkg::num_bd_chan-1:0] bd_tready;
  logic                                bd_tlast;
  pcie_rc_pkg::tlp_data_t              bd_tdata;
  logic                                cq_tvalid;
  logic                                cq_tready;
  pcie_rc_pkg::tlp_data_t              cq_tdata;
  dma_reg_pkg::sw_ptr_t                ch0_s2c_sw_ptr;
  dma_reg_pkg::sw_ptr_t                ch0_c2s_sw_ptr;
  dma_reg_pkg::sw_ptr_t                ch1_s2c_sw_ptr;
  dma_reg_pkg::sw_ptr_t                ch1_c2s_sw_ptr;

  dma_reg_pkg::sw_ptr_t                exp_ptr [4];
  logic [31:0]                         lcg_state;
  int                                  error_count = 0;
  int                                  cycle_count = 0;

  rc_cq_top dut_i (.*);

  always #10 user_clk = ~user_clk;

  always @(posedge user_clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles)
    begin
      $display("Timeout: the tests did not finish within %0d cycles", max_cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic pcie_rc_pkg::tlp_data_t rand_beat();
    pcie_rc_pkg::tlp_data_t d;
    for (int i = 0; i < 8; i++)
    begin
      d[i*32 +: 32] = lcg_next();
    end
    return d;
  endfunction

  task automatic check_value(input string name, input logic [255:0] expected,
                             input logic [255:0] actual);
    if (expected !== actual)
    begin
      $display("Fail at %0t: %s expected %h actual %h", $time, name, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_rc_outputs(
    input pcie_rc_pkg::tlp_data_t              data,
    input logic                                last,
    input pcie_rc_pkg::tlp_keep_t              keep,
    input pcie_rc_pkg::rc_user_t               user,
    input logic                                exp_bp,
    input logic [pcie_rc_pkg::num_bd_chan-1:0] exp_bd_vec,
    input logic                                exp_ready
  );
    check_value("rc_tready", 256'(exp_ready), 256'(rc_tready));
    check_value("bp_tvalid", 256'(exp_bp), 256'(bp_tvalid));
    check_value("bd_tvalid", 256'(exp_bd_vec), 256'(bd_tvalid));
    check_value("bp_tlast", 256'(last), 256'(bp_tlast));
    check_value("bd_tlast", 256'(last), 256'(bd_tlast));
    check_value("bp_tdata", data, bp_tdata);
    check_value("bd_tdata", data, bd_tdata);
    check_value("bp_tkeep", 256'(keep), 256'(bp_tkeep));
    check_value("bp_tuser", 256'(user), 256'(bp_tuser));
  endtask

  // Present one beat, hold the chosen sink off for stall cycles, then let it go
  task automatic send_rc_beat(
    input pcie_rc_pkg::tlp_data_t data,
    input logic                   last,
    input logic                   exp_bd,
    input pcie_rc_pkg::bd_chan_t  exp_chan,
    input int                     stall
  );
    logic [pcie_rc_pkg::num_bd_chan-1:0] exp_bd_vec;
    pcie_rc_pkg::tlp_keep_t              keep;
    pcie_rc_pkg::rc_user_t               user;
    exp_bd_vec = exp_bd ? (4'b0001 << exp_chan) : 4'b0000;
    keep = pcie_rc_pkg::tlp_keep_t'(lcg_next());
    user = pcie_rc_pkg::rc_user_t'({lcg_next(), lcg_next(), lcg_next()});
    @(posedge user_clk);
    rc_tvalid <= 1'b1;
    rc_tlast  <= last;
    rc_tkeep  <= keep;
    rc_tdata  <= data;
    rc_tuser  <= user;
    if (stall > 0)
    begin
      // Only the selected sink stalls while the others stay ready
      if (exp_bd)
      begin
        bd_tready <= ~exp_bd_vec;
      end
      else
      begin
        bp_tready <= 1'b0;
      end
    end
    for (int i = 0; i < stall; i++)
    begin
      @(negedge user_clk);
      check_rc_outputs(data, last, keep, user, !exp_bd, exp_bd_vec, 1'b0);
      @(posedge user_clk);
    end
    bd_tready <= '1;
    bp_tready <= 1'b1;
    @(negedge user_clk);
    check_rc_outputs(data, last, keep, user, !exp_bd, exp_bd_vec, 1'b1);
  endtask

  task automatic rc_idle();
    @(posedge user_clk);
    rc_tvalid <= 1'b0;
    @(negedge user_clk);
    check_value("bp_tvalid", 256'(1'b0), 256'(bp_tvalid));
    check_value("bd_tvalid", 256'(4'b0000), 256'(bd_tvalid));
  endtask

  task automatic check_ptrs();
    check_value("ch0_s2c_sw_ptr", 256'(exp_ptr[0]), 256'(ch0_s2c_sw_ptr));
    check_value("ch0_c2s_sw_ptr", 256'(exp_ptr[1]), 256'(ch0_c2s_sw_ptr));
    check_value("ch1_s2c_sw_ptr", 256'(exp_ptr[2]), 256'(ch1_s2c_sw_ptr));
    check_value("ch1_c2s_sw_ptr", 256'(exp_ptr[3]), 256'(ch1_c2s_sw_ptr));
  endtask

  task automatic send_cq_write(input pcie_rc_pkg::tlp_data_t data, input logic ready);
    @(posedge user_clk);
    cq_tvalid <= 1'b1;
    cq_tready <= ready;
    cq_tdata  <= data;
    @(negedge user_clk);
    check_ptrs();
    @(posedge user_clk);
    cq_tvalid <= 1'b0;
    cq_tready <= 1'b1;
    // The matching register loads on the edge that accepts the beat
    for (int k = 0; k < 4; k++)
    begin
      if (ready && data[15:0] == ptr_offsets[k])
      begin
        exp_ptr[k] = data[dma_reg_pkg::sw_ptr_lsb +: 27];
      end
    end
    @(negedge user_clk);
    check_ptrs();
  endtask

  task automatic test_reset_state();
    pcie_rc_pkg::tlp_data_t d;
    @(negedge user_clk);
    check_ptrs();
    d = rand_beat();
    d[pcie_rc_pkg::bd_flag_bit] = 1'b0;
    send_rc_beat(d, 1'b1, 1'b0, 2'd0, 0);
    rc_idle();
  endtask

  task automatic test_bypass();
    pcie_rc_pkg::tlp_data_t d;
    for (int b = 0; b < 4; b++)
    begin
      d = rand_beat();
      d[pcie_rc_pkg::bd_flag_bit] = (b == 2);
      send_rc_beat(d, b == 3, 1'b0, 2'd0, 0);
    end
    rc_idle();
  endtask

  task automatic test_bd_channels();
    pcie_rc_pkg::tlp_data_t d;
    for (int c = 0; c < 4; c++)
    begin
      d = rand_beat();
      d[pcie_rc_pkg::bd_flag_bit] = 1'b1;
      d[pcie_rc_pkg::bd_chan_lsb +: 2] = pcie_rc_pkg::bd_chan_t'(c);
      send_rc_beat(d, 1'b0, 1'b1, pcie_rc_pkg::bd_chan_t'(c), 0);
      // Later beat that would decode as bypass to another channel if it were a first beat
      d = rand_beat();
      d[pcie_rc_pkg::bd_flag_bit] = 1'b0;
      d[pcie_rc_pkg::bd_chan_lsb +: 2] = pcie_rc_pkg::bd_chan_t'(c + 1);
      send_rc_beat(d, 1'b0, 1'b1, pcie_rc_pkg::bd_chan_t'(c), 0);
      send_rc_beat(rand_beat(), 1'b1, 1'b1, pcie_rc_pkg::bd_chan_t'(c), 0);
    end
    rc_idle();
  endtask

  task automatic test_back_pressure();
    pcie_rc_pkg::tlp_data_t d;
    d = rand_beat();
    d[pcie_rc_pkg::bd_flag_bit] = 1'b1;
    d[pcie_rc_pkg::bd_chan_lsb +: 2] = 2'd2;
    send_rc_beat(d, 1'b0, 1'b1, 2'd2, 0);
    send_rc_beat(rand_beat(), 1'b0, 1'b1, 2'd2, 3);
    send_rc_beat(rand_beat(), 1'b1, 1'b1, 2'd2, 2);
    d = rand_beat();
    d[pcie_rc_pkg::bd_flag_bit] = 1'b0;
    send_rc_beat(d, 1'b0, 1'b0, 2'd0, 4);
    send_rc_beat(rand_beat(), 1'b0, 1'b0, 2'd0, 0);
    send_rc_beat(rand_beat(), 1'b1, 1'b0, 2'd0, 2);
    rc_idle();
  endtask

  task automatic test_ptr_snoop();
    pcie_rc_pkg::tlp_data_t d;
    for (int k = 0; k < 4; k++)
    begin
      d = rand_beat();
      d[15:0] = ptr_offsets[k];
      send_cq_write(d, 1'b1);
    end
    d = rand_beat();
    d[15:0] = dma_reg_pkg::ch1_s2c_ptr_offset;
    send_cq_write(d, 1'b0);
    d = rand_beat();
    d[15:0] = 16'h0010;
    send_cq_write(d, 1'b1);
  endtask

  initial
  begin
    lcg_state = 32'h8a95;
    for (int k = 0; k < 4; k++)
    begin
      exp_ptr[k] = '0;
    end
    user_reset <= 1'b1;
    rc_tvalid  <= 1'b0;
    rc_tlast   <= 1'b0;
    rc_tkeep   <= '0;
    rc_tdata   <= '0;
    rc_tuser   <= '0;
    bp_tready  <= 1'b1;
    bd_tready  <= '1;
    cq_tvalid  <= 1'b0;
    cq_tready  <= 1'b1;
    cq_tdata   <= '0;
    repeat (2) @(posedge user_clk);
    user_reset <= 1'b0;
    test_reset_state();
    test_bypass();
    test_bd_channels();
    test_back_pressure();
    test_ptr_snoop();
    $display("Errors: %0d", error_count);
    if (error_count == 0)
    begin
      $display("TESTBENCH PASSED");
    end
    else
    begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
pcie_rc_pkg.sv
dma_reg_pkg.sv
rc_pkt_tracker.sv
rc_steer.sv
sw_ptr_snoop.sv
rc_cq_top.sv
rc_cq_sva.sv
tb_rc_cq_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_rc_cq_top \
  -Mdir obj_dir -o sim_rc_cq
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_rc_cq > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH PASSED" sim.log; then
  exit 0
else
  echo "Pass message not found in sim.log"
  exit 1
fi
